//--- sim.f
src/isaPkg.sv
src/axiPkg.sv
src/fieldDecoder.sv
src/operandGen.sv
src/axiLiteRegs.sv
src/decoderTop.sv
+incdir+verification
verification/decoderTb.sv

//--- run.sh
#!/bin/sh
# Builds the decode unit testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sim.f --top-module decoderTb -o decoderSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/decoderSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
exit 0

//--- verification/golden_decode.txt
# columns, all hex: pc instr ctrl regs imm target, then the instruction after #
# ctrl: flags in bits 8:0, mask in 11:9, alu code in 23:16; regs: rs 4:0, rt 12:8, wr 20:16
00000100 00221820 00010161 00030201 00000000 00000000 # add $3, $1, $2
00000104 012a402b 00090161 00080a09 00000000 00000000 # sltu $8, $9, $10
00000108 00a62027 00100161 00040605 00000000 00000000 # nor $4, $5, $6
0000010c 00071140 000a01a1 00020007 00000005 00000000 # sll $2, $7, 5
00000110 2085fffd 000101a1 00050004 fffffffd 00000000 # addi $5, $4, -3
00000114 30e68001 000501a1 00060007 00008001 00000000 # andi $6, $7, 0x8001
00000118 3c091234 00060181 00090000 12340000 00000000 # lui $9, 0x1234
00000200 10220004 00210063 00000201 00000000 00000205 # beq $1, $2, +4
00000300 1464fff0 00220063 00000403 00000000 000002f1 # bne $3, $4, -16
00000005 18a0fff0 00230063 00000005 00000000 003ffff6 # blez $5, -16 wraps below zero
00001000 1cc00010 00240063 00000006 00000000 00001011 # bgtz $6, +16
00000040 04e10002 00250063 00000107 00000000 00000043 # bgez $7, +2
00000040 04e0ffff 00260063 00000007 00000000 00000040 # bltz $7, -1
00000123 0b2abcde 00400003 00000000 00000000 002abcde # j
00000100 0c012345 00410183 001f0000 00000102 00012345 # jal
00000200 03e00008 00420027 0000001f 00000000 00000000 # jr $31
003fffff 0080f809 004201a7 001f0004 00400001 00000000 # jalr $4, link past the pc range
00000400 8128fffc 000101b9 00080009 fffffffc 00000000 # lb $8, -4($9)
00000404 91280004 000103b9 00080009 00000004 00000000 # lbu $8, 4($9)
00000408 85280006 000105b9 00080009 00000006 00000000 # lh $8, 6($9)
0000040c 95280008 000107b9 00080009 00000008 00000000 # lhu $8, 8($9)
00000410 8d287ffc 000109b9 00080009 00007ffc 00000000 # lw $8, 0x7ffc($9)
00000414 ad6afff8 000108e9 00000a0b fffffff8 00000000 # sw $10, -8($11)
00000500 4005b800 00120041 00000500 00000000 00000000 # mtc0 $5, pass code
00000504 4005c000 00130041 00000500 00000000 00000000 # mtc0 $5, fail code
00000508 4005c800 00140041 00000500 00000000 00000000 # mtc0 $5, done code
0000050c 40050800 00000041 00000500 00000000 00000000 # mtc0 $5, other code
00000600 ffffffff 00000000 00000000 00000000 00000000 # unknown opcode
00000604 00850018 00000000 00000000 00000000 00000000 # mult $4, $5
00000608 0085001a 00000000 00000000 00000000 00000000 # div $4, $5

//--- verification/axiHostTasks.svh
//********************
// AXI4-Lite host tasks for the decode unit testbench, included in its
// top module. Each wait is a bounded loop; ready delays are random.
//********************
`ifndef AXI_HOST_TASKS_SVH
`define AXI_HOST_TASKS_SVH

	task automatic writeReg(input axiPkg::axiAddr addr, input axiPkg::axiData data,
		input axiPkg::axiStrb strobe);
		int waitCount;
		int idleCycles;
		if (timedOut)
			return;
		@(posedge clk);
		writeReq.awaddr <= addr;
		writeReq.wdata <= data;
		writeReq.wstrb <= strobe;
		writeReq.awvalid <= 1'b1;
		writeReq.wvalid <= 1'b1;
		waitCount = 0;
		do
		begin
			@(negedge clk);
			waitCount++;
		end
		while (!(writeRsp.awready && writeRsp.wready) && waitCount <= TIMEOUT_CYCLES);
		if (!(writeRsp.awready && writeRsp.wready))
		begin
			failTimeout("the write address and data were never accepted");
			return;
		end
		@(posedge clk);				// handshake edge
		writeReq.awvalid <= 1'b0;
		writeReq.wvalid <= 1'b0;
		waitCount = 0;
		while (!writeRsp.bvalid && waitCount <= TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			waitCount++;
		end
		if (!writeRsp.bvalid)
		begin
			failTimeout("no write response arrived");
			return;
		end
		checkValue("bresp", 32'(writeRsp.bresp), 32'(axiPkg::RESP_OKAY));
		idleCycles = int'($urandom % 4);
		repeat (idleCycles)
		begin
			@(negedge clk);			// response must hold while bready is low
			if (!writeRsp.bvalid)
			begin
				errorCount++;
				$display("bvalid dropped at %0t ns before bready was given", $time);
			end
		end
		@(posedge clk);
		writeReq.bready <= 1'b1;
		@(posedge clk);				// slave sees bready here
		writeReq.bready <= 1'b0;
	endtask

	task automatic readReg(input axiPkg::axiAddr addr, output axiPkg::axiData data);
		int waitCount;
		int idleCycles;
		data = '0;
		if (timedOut)
			return;
		@(posedge clk);
		readReq.araddr <= addr;
		readReq.arvalid <= 1'b1;
		waitCount = 0;
		do
		begin
			@(negedge clk);
			waitCount++;
		end
		while (!readRsp.arready && waitCount <= TIMEOUT_CYCLES);
		if (!readRsp.arready)
		begin
			failTimeout("the read address was never accepted");
			return;
		end
		@(posedge clk);
		readReq.arvalid <= 1'b0;
		waitCount = 0;
		while (!readRsp.rvalid && waitCount <= TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			waitCount++;
		end
		if (!readRsp.rvalid)
		begin
			failTimeout("no read data arrived");
			return;
		end
		data = readRsp.rdata;
		checkValue("rresp", 32'(readRsp.rresp), 32'(axiPkg::RESP_OKAY));
		idleCycles = int'($urandom % 4);
		repeat (idleCycles)
		begin
			@(negedge clk);			// response must hold while rready is low
			if (!readRsp.rvalid)
			begin
				errorCount++;
				$display("rvalid dropped at %0t ns before rready was given", $time);
			end
			checkValue("rdata", readRsp.rdata, data);
		end
		@(posedge clk);
		readReq.rready <= 1'b1;
		@(posedge clk);
		readReq.rready <= 1'b0;
	endtask

`endif

//--- verification/decoderTb.sv
//********************
// Testbench for the decode unit. Checks bus behavior, then replays the
// golden vectors: writes PC and instruction, reads back the decode words.
//********************
`timescale 1ns/1ps
`default_nettype none

module decoderTb;

	localparam int ADDRESS_WIDTH = 22;
	localparam int TIMEOUT_CYCLES = 32;
	localparam axiPkg::axiAddr UNMAPPED_LOW = 6'h18;
	localparam axiPkg::axiAddr UNMAPPED_HIGH = 6'h3c;

	logic clk;
	logic reset;
	axiPkg::axiWriteReq writeReq;
	axiPkg::axiWriteRsp writeRsp;
	axiPkg::axiReadReq readReq;
	axiPkg::axiReadRsp readRsp;

	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	bit timedOut = 1'b0;

	task automatic checkValue(input string signalName, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("error at %0t ns: %s is %h, expected %h", $time, signalName,
				actual, expected);
		end
	endtask

	task automatic failTimeout(input string reason);
		errorCount++;
		timedOut = 1'b1;
		$display("timeout at %0t ns: %s", $time, reason);
	endtask

	task automatic reportTest(input string label, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore)
			$display("test %0d %s: ok", testCount, label);
		else
			$display("test %0d %s: %0d errors", testCount, label, errorCount - errorsBefore);
	endtask

	`include "axiHostTasks.svh"

	decoderTop #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH)
	) decoderTop_inst (
		.i_clk(clk),
		.i_reset(reset),
		.i_writeReq(writeReq),
		.o_writeRsp(writeRsp),
		.i_readReq(readReq),
		.o_readRsp(readRsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		int fd;
		int lineLen;
		int fields;
		int errorsBefore;
		int vectorCount;
		string line;
		axiPkg::axiData pcValue;
		axiPkg::axiData instrValue;
		axiPkg::axiData expCtrl;
		axiPkg::axiData expRegs;
		axiPkg::axiData expImm;
		axiPkg::axiData expTarget;
		axiPkg::axiData ctrlWord;
		axiPkg::axiData regsWord;
		axiPkg::axiData immWord;
		axiPkg::axiData targetWord;

		void'($urandom(35));
		vectorCount = 0;
		reset = 1'b1;
		writeReq = '0;
		readReq = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		errorsBefore = errorCount;
		readReg(axiPkg::REG_PC, ctrlWord);
		checkValue("PC", ctrlWord, 32'h0);
		readReg(axiPkg::REG_INSTR, ctrlWord);
		checkValue("INSTR", ctrlWord, 32'h0);
		reportTest("registers after reset", errorsBefore);

		errorsBefore = errorCount;
		readReg(UNMAPPED_LOW, ctrlWord);
		checkValue("rdata at 0x18", ctrlWord, 32'h0);
		readReg(UNMAPPED_HIGH, ctrlWord);
		checkValue("rdata at 0x3c", ctrlWord, 32'h0);
		reportTest("unmapped offsets", errorsBefore);

		errorsBefore = errorCount;
		writeReg(axiPkg::REG_INSTR, 32'h11223344, 4'hf);
		writeReg(axiPkg::REG_INSTR, 32'haabbccdd, 4'b0101);		// bytes 0 and 2 only
		readReg(axiPkg::REG_INSTR, ctrlWord);
		checkValue("INSTR", ctrlWord, 32'h11bb33dd);
		reportTest("partial strobe write", errorsBefore);

		fd = $fopen("verification/golden_decode.txt", "r");
		if (fd == 0)
		begin
			errorCount++;
			$display("could not open verification/golden_decode.txt");
		end
		else
		begin
			while (!$feof(fd) && !timedOut)
			begin
				lineLen = $fgets(line, fd);
				if (lineLen < 2 || line.getc(0) == "#")
					continue;
				fields = $sscanf(line, "%h %h %h %h %h %h", pcValue, instrValue,
					expCtrl, expRegs, expImm, expTarget);
				if (fields != 6)
				begin
					errorCount++;
					$display("golden line could not be parsed: %s", line);
					continue;
				end
				vectorCount++;
				errorsBefore = errorCount;
				writeReg(axiPkg::REG_PC, pcValue, 4'hf);
				writeReg(axiPkg::REG_INSTR, instrValue, 4'hf);
				readReg(axiPkg::REG_CTRL, ctrlWord);
				readReg(axiPkg::REG_REGS, regsWord);
				readReg(axiPkg::REG_IMM, immWord);
				readReg(axiPkg::REG_TARGET, targetWord);
				if (!timedOut)
				begin
					checkValue("CTRL", ctrlWord, expCtrl);
					checkValue("REGS", regsWord, expRegs);
					checkValue("IMM", immWord, expImm);
					checkValue("TARGET", targetWord, expTarget);
				end
				reportTest($sformatf("decode %h at pc %h", instrValue, pcValue), errorsBefore);
			end
			$fclose(fd);
			if (vectorCount == 0)
			begin
				errorCount++;
				$display("the golden file held no vectors");
			end
		end

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/decoderTop.sv
//********************
// Top level of the register-mapped decode unit. The host writes PC and
// instruction over AXI4-Lite and reads back the decoded fields.
//********************
`timescale 1ns/1ps
`default_nettype none

module decoderTop #(
	parameter int ADDRESS_WIDTH = 22		// pc and target width, 16 to 26
)
(
	input wire i_clk,
	input wire i_reset,
	input wire axiPkg::axiWriteReq i_writeReq,
	output axiPkg::axiWriteRsp o_writeRsp,
	input wire axiPkg::axiReadReq i_readReq,
	output axiPkg::axiReadRsp o_readRsp
);

	logic [ADDRESS_WIDTH-1:0] pc;
	logic [ADDRESS_WIDTH-1:0] target;
	isaPkg::instrWord instr;
	isaPkg::decodedCtrl ctrl;
	isaPkg::operandKind operandKind;
	isaPkg::dataWord immediate;

	if (ADDRESS_WIDTH < 16 || ADDRESS_WIDTH > 26)
	begin : widthCheck
		$error("ADDRESS_WIDTH must lie between 16 and 26");
	end

	axiLiteRegs #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH)
	) axiLiteRegs_inst (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_writeReq(i_writeReq),
		.o_writeRsp(o_writeRsp),
		.i_readReq(i_readReq),
		.o_readRsp(o_readRsp),
		.o_pc(pc),
		.o_instr(instr),
		.i_ctrl(ctrl),
		.i_immediate(immediate),
		.i_target(target)
	);

	fieldDecoder fieldDecoder_inst (
		.i_instr(instr),
		.o_ctrl(ctrl),
		.o_operandKind(operandKind)
	);

	operandGen #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH)
	) operandGen_inst (
		.i_pc(pc),
		.i_instr(instr),
		.i_operandKind(operandKind),
		.o_immediate(immediate),
		.o_target(target)
	);

endmodule

`default_nettype wire

//--- src/axiLiteRegs.sv
//********************
// AXI4-Lite slave front end. Holds the PC and instruction registers,
// and returns the packed decode results on reads, one cycle after
// the address handshake.
//********************
`timescale 1ns/1ps
`default_nettype none

module axiLiteRegs #(
	parameter int ADDRESS_WIDTH = 22
)
(
	input wire i_clk,
	input wire i_reset,
	input wire axiPkg::axiWriteReq i_writeReq,
	output axiPkg::axiWriteRsp o_writeRsp,
	input wire axiPkg::axiReadReq i_readReq,
	output axiPkg::axiReadRsp o_readRsp,
	output logic [ADDRESS_WIDTH-1:0] o_pc,
	output isaPkg::instrWord o_instr,
	input wire isaPkg::decodedCtrl i_ctrl,
	input wire isaPkg::dataWord i_immediate,
	input wire [ADDRESS_WIDTH-1:0] i_target
);

	typedef enum logic {
		IDLE,
		RESPOND
	} chanState;

	chanState writeState;
	chanState readState;
	logic writeReady;		// awready and wready together
	logic readReady;
	axiPkg::axiData readWord;
	axiPkg::axiData readData;

	function automatic axiPkg::axiData mergeBytes(input axiPkg::axiData oldWord,
		input axiPkg::axiData newWord, input axiPkg::axiStrb strobe);
		axiPkg::axiData merged;
		merged = oldWord;
		for (int b = 0; b < 4; b++)
			if (strobe[b])
				merged[8*b +: 8] = newWord[8*b +: 8];
		return merged;
	endfunction

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			writeState <= IDLE;
			writeReady <= 1'b0;
			o_pc <= '0;
			o_instr <= '0;
		end
		else
		begin
			writeReady <= 1'b0;
			case (writeState)
				IDLE:
				begin
					if (writeReady)								// handshake in this cycle
					begin
						writeState <= RESPOND;
						if (i_writeReq.awaddr == axiPkg::REG_PC)
							o_pc <= ADDRESS_WIDTH'(mergeBytes(axiPkg::axiData'(o_pc),
								i_writeReq.wdata, i_writeReq.wstrb));
						else if (i_writeReq.awaddr == axiPkg::REG_INSTR)
							o_instr <= mergeBytes(o_instr, i_writeReq.wdata, i_writeReq.wstrb);
					end
					else if (i_writeReq.awvalid && i_writeReq.wvalid)
						writeReady <= 1'b1;
				end
				default:
				begin
					if (i_writeReq.bready)
						writeState <= IDLE;
				end
			endcase
		end
	end

	always_comb
	begin
		case (i_readReq.araddr)
			axiPkg::REG_PC: readWord = axiPkg::axiData'(o_pc);
			axiPkg::REG_INSTR: readWord = o_instr;
			axiPkg::REG_CTRL: readWord = {8'd0, i_ctrl.aluCode, 4'd0, i_ctrl.memSize,
				i_ctrl.writesBack, i_ctrl.usesImm, i_ctrl.usesRt, i_ctrl.usesRs,
				i_ctrl.memRead, i_ctrl.memValid, i_ctrl.jumpReg, i_ctrl.isBranch,
				i_ctrl.usesAlu};
			axiPkg::REG_REGS: readWord = {11'd0, i_ctrl.writeAddr, 3'd0, i_ctrl.rtAddr,
				3'd0, i_ctrl.rsAddr};
			axiPkg::REG_IMM: readWord = i_immediate;
			axiPkg::REG_TARGET: readWord = axiPkg::axiData'(i_target);
			default: readWord = '0;						// unmapped
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			readState <= IDLE;
			readReady <= 1'b0;
		end
		else
		begin
			readReady <= 1'b0;
			case (readState)
				IDLE:
				begin
					if (readReady)
						readState <= RESPOND;
					else if (i_readReq.arvalid)
						readReady <= 1'b1;
				end
				default:
				begin
					if (i_readReq.rready)
						readState <= IDLE;
				end
			endcase
		end
	end

	// data held for the whole response
	always_ff @(posedge i_clk)
	begin
		if (readReady)
			readData <= readWord;
	end

	assign o_writeRsp = '{awready: writeReady, wready: writeReady,
		bresp: axiPkg::RESP_OKAY, bvalid: (writeState == RESPOND)};
	assign o_readRsp = '{arready: readReady, rdata: readData,
		rresp: axiPkg::RESP_OKAY, rvalid: (readState == RESPOND)};

	property holdUntilReady(valid, ready);
		@(posedge i_clk) disable iff (i_reset) valid && !ready |=> valid;
	endproperty

	assert property (holdUntilReady(o_writeRsp.bvalid, i_writeReq.bready))
		else $error("bvalid dropped before bready");
	assert property (holdUntilReady(o_readRsp.rvalid, i_readReq.rready))
		else $error("rvalid dropped before rready");
	assert property (@(posedge i_clk) disable iff (i_reset)
		o_readRsp.rvalid && !i_readReq.rready |=> $stable(o_readRsp.rdata))
		else $error("rdata changed while waiting for rready");

endmodule

`default_nettype wire

//--- src/operandGen.sv
//********************
// Forms the immediate, the link value and the branch or jump target
// from the PC and instruction, selected by the decoder's operand kind.
//********************
`timescale 1ns/1ps
`default_nettype none

module operandGen #(
	parameter int ADDRESS_WIDTH = 22
)
(
	input wire [ADDRESS_WIDTH-1:0] i_pc,
	input wire isaPkg::instrWord i_instr,
	input wire isaPkg::operandKind i_operandKind,
	output isaPkg::dataWord o_immediate,
	output logic [ADDRESS_WIDTH-1:0] o_target
);

	isaPkg::dataWord linkValue;
	logic [ADDRESS_WIDTH-1:0] branchTarget;
	logic [ADDRESS_WIDTH-1:0] jumpTarget;
	logic isJal;

	assign linkValue = isaPkg::dataWord'(i_pc) + 32'd2;	// pc + 2, full 32 bits
	assign branchTarget = i_pc + ADDRESS_WIDTH'(1) + ADDRESS_WIDTH'($signed(i_instr[15:0]));
	assign jumpTarget = i_instr[ADDRESS_WIDTH-1:0];
	assign isJal = (i_instr[31:26] == isaPkg::OP_JAL);

	always_comb
	begin
		o_immediate = '0;
		o_target = '0;
		case (i_operandKind)
			isaPkg::KIND_SHIFT_AMOUNT:
				o_immediate = {27'd0, i_instr[10:6]};
			isaPkg::KIND_SIGN_EXTEND:
				o_immediate = {{16{i_instr[15]}}, i_instr[15:0]};
			isaPkg::KIND_ZERO_EXTEND:
				o_immediate = {16'd0, i_instr[15:0]};
			isaPkg::KIND_UPPER_IMMEDIATE:
				o_immediate = {i_instr[15:0], 16'd0};
			isaPkg::KIND_LINK:
				o_immediate = linkValue;					// jalr, target comes from rs
			isaPkg::KIND_BRANCH_REL:
				o_target = branchTarget;
			isaPkg::KIND_JUMP_ABS:
			begin
				o_target = jumpTarget;
				if (isJal)
					o_immediate = linkValue;				// jal also links
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- src/fieldDecoder.sv
//********************
// Classifies the opcode, function and mtc0 fields of an instruction
// into control flags, ALU code and register addresses. Purely combinational;
// the operand kind tells operandGen which immediate and target to form.
//********************
`timescale 1ns/1ps
`default_nettype none

module fieldDecoder
(
	input wire isaPkg::instrWord i_instr,
	output isaPkg::decodedCtrl o_ctrl,
	output isaPkg::operandKind o_operandKind
);

	logic [5:0] opcode;
	logic [5:0] funct;
	isaPkg::regAddr rsField;
	isaPkg::regAddr rtField;
	isaPkg::regAddr rdField;
	logic shiftImm;

	assign opcode = i_instr[31:26];
	assign funct = i_instr[5:0];
	assign rsField = i_instr[25:21];
	assign rtField = i_instr[20:16];
	assign rdField = i_instr[15:11];		// also the mtc0 status code
	assign shiftImm = (funct == isaPkg::FN_SLL) || (funct == isaPkg::FN_SRL) ||
		(funct == isaPkg::FN_SRA);

	// mul, div and unknown codes land on NOP
	function automatic isaPkg::aluCtl rTypeAlu(input logic [5:0] fn);
		case (fn)
			isaPkg::FN_ADD: return isaPkg::ALU_ADD;
			isaPkg::FN_ADDU: return isaPkg::ALU_ADDU;
			isaPkg::FN_SUB: return isaPkg::ALU_SUB;
			isaPkg::FN_SUBU: return isaPkg::ALU_SUBU;
			isaPkg::FN_AND: return isaPkg::ALU_AND;
			isaPkg::FN_OR: return isaPkg::ALU_OR;
			isaPkg::FN_XOR: return isaPkg::ALU_XOR;
			isaPkg::FN_NOR: return isaPkg::ALU_NOR;
			isaPkg::FN_SLT: return isaPkg::ALU_SLT;
			isaPkg::FN_SLTU: return isaPkg::ALU_SLTU;
			isaPkg::FN_SLL: return isaPkg::ALU_SLL;
			isaPkg::FN_SRL: return isaPkg::ALU_SRL;
			isaPkg::FN_SRA: return isaPkg::ALU_SRA;
			isaPkg::FN_SLLV: return isaPkg::ALU_SLLV;
			isaPkg::FN_SRLV: return isaPkg::ALU_SRLV;
			isaPkg::FN_SRAV: return isaPkg::ALU_SRAV;
			isaPkg::FN_JR: return isaPkg::ALU_JR;
			isaPkg::FN_JALR: return isaPkg::ALU_JR;	// jalr shares the jr code
			default: return isaPkg::ALU_NOP;
		endcase
	endfunction

	function automatic isaPkg::aluCtl immAlu(input logic [5:0] op);
		case (op)
			isaPkg::OP_ADDI: return isaPkg::ALU_ADD;
			isaPkg::OP_ADDIU: return isaPkg::ALU_ADDU;
			isaPkg::OP_SLTI: return isaPkg::ALU_SLT;
			isaPkg::OP_SLTIU: return isaPkg::ALU_SLTU;
			isaPkg::OP_ANDI: return isaPkg::ALU_AND;
			isaPkg::OP_XORI: return isaPkg::ALU_XOR;
			default: return isaPkg::ALU_OR;			// ori, and lui as 0 | imm
		endcase
	endfunction

	always_comb
	begin
		o_ctrl = '0;
		o_operandKind = isaPkg::KIND_NONE;
		case (opcode)
			isaPkg::OP_RTYPE:
			begin
				o_ctrl.aluCode = rTypeAlu(funct);
				if (o_ctrl.aluCode != isaPkg::ALU_NOP)
				begin
					o_ctrl.usesAlu = 1'b1;
					o_ctrl.usesRs = 1'b1;
					o_ctrl.rsAddr = rsField;
					if (funct == isaPkg::FN_JR || funct == isaPkg::FN_JALR)
					begin
						o_ctrl.isBranch = 1'b1;
						o_ctrl.jumpReg = 1'b1;
						if (funct == isaPkg::FN_JALR)
						begin
							o_ctrl.usesImm = 1'b1;
							o_ctrl.writesBack = 1'b1;
							o_ctrl.writeAddr = isaPkg::linkReg;
							o_operandKind = isaPkg::KIND_LINK;
						end
					end
					else
					begin
						o_ctrl.writesBack = 1'b1;
						o_ctrl.writeAddr = rdField;
						if (shiftImm)
						begin
							o_ctrl.rsAddr = rtField;			// shifted value comes from rt
							o_ctrl.usesImm = 1'b1;
							o_operandKind = isaPkg::KIND_SHIFT_AMOUNT;
						end
						else
						begin
							o_ctrl.usesRt = 1'b1;
							o_ctrl.rtAddr = rtField;
						end
					end
				end
			end

			isaPkg::OP_ADDI, isaPkg::OP_ADDIU, isaPkg::OP_SLTI, isaPkg::OP_SLTIU,
			isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI, isaPkg::OP_LUI:
			begin
				o_ctrl.usesAlu = 1'b1;
				o_ctrl.aluCode = immAlu(opcode);
				o_ctrl.usesImm = 1'b1;
				o_ctrl.writesBack = 1'b1;
				o_ctrl.writeAddr = rtField;
				o_ctrl.usesRs = (opcode != isaPkg::OP_LUI);
				o_ctrl.rsAddr = (opcode != isaPkg::OP_LUI) ? rsField : '0;
				case (opcode)
					isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI:
						o_operandKind = isaPkg::KIND_ZERO_EXTEND;
					isaPkg::OP_LUI:
						o_operandKind = isaPkg::KIND_UPPER_IMMEDIATE;
					default:
						o_operandKind = isaPkg::KIND_SIGN_EXTEND;
				endcase
			end

			isaPkg::OP_BEQ, isaPkg::OP_BNE, isaPkg::OP_BLEZ, isaPkg::OP_BGTZ,
			isaPkg::OP_REGIMM:
			begin
				o_ctrl.isBranch = 1'b1;
				o_ctrl.usesAlu = 1'b1;
				o_ctrl.usesRs = 1'b1;
				o_ctrl.rsAddr = rsField;
				o_ctrl.usesRt = 1'b1;
				o_ctrl.rtAddr = rtField;
				o_operandKind = isaPkg::KIND_BRANCH_REL;
				case (opcode)
					isaPkg::OP_BEQ: o_ctrl.aluCode = isaPkg::ALU_BEQ;
					isaPkg::OP_BNE: o_ctrl.aluCode = isaPkg::ALU_BNE;
					isaPkg::OP_BLEZ: o_ctrl.aluCode = isaPkg::ALU_BLEZ;
					isaPkg::OP_BGTZ: o_ctrl.aluCode = isaPkg::ALU_BGTZ;
					default:
					begin
						if (i_instr[16])						// 1 = bgez, 0 = bltz
							o_ctrl.aluCode = isaPkg::ALU_BGEZ;
						else
							o_ctrl.aluCode = isaPkg::ALU_BLTZ;
					end
				endcase
			end

			isaPkg::OP_J, isaPkg::OP_JAL:
			begin
				o_ctrl.isBranch = 1'b1;
				o_ctrl.usesAlu = 1'b1;
				o_ctrl.aluCode = isaPkg::ALU_J;
				o_operandKind = isaPkg::KIND_JUMP_ABS;
				if (opcode == isaPkg::OP_JAL)
				begin
					o_ctrl.aluCode = isaPkg::ALU_JAL;
					o_ctrl.usesImm = 1'b1;				// return address
					o_ctrl.writesBack = 1'b1;
					o_ctrl.writeAddr = isaPkg::linkReg;
				end
			end

			isaPkg::OP_LB, isaPkg::OP_LBU, isaPkg::OP_LH, isaPkg::OP_LHU, isaPkg::OP_LW,
			isaPkg::OP_SB, isaPkg::OP_SH, isaPkg::OP_SW:
			begin
				o_ctrl.usesAlu = 1'b1;
				o_ctrl.aluCode = isaPkg::ALU_ADD;		// base + offset
				o_ctrl.memValid = 1'b1;
				o_ctrl.usesRs = 1'b1;
				o_ctrl.rsAddr = rsField;
				o_ctrl.usesImm = 1'b1;
				o_operandKind = isaPkg::KIND_SIGN_EXTEND;
				case (opcode)
					isaPkg::OP_LB, isaPkg::OP_SB: o_ctrl.memSize = isaPkg::MASK_BYTE;
					isaPkg::OP_LBU: o_ctrl.memSize = isaPkg::MASK_BYTE_U;
					isaPkg::OP_LH, isaPkg::OP_SH: o_ctrl.memSize = isaPkg::MASK_HALF;
					isaPkg::OP_LHU: o_ctrl.memSize = isaPkg::MASK_HALF_U;
					default: o_ctrl.memSize = isaPkg::MASK_WORD;
				endcase
				if (opcode[3])								// stores are 0x28 and up
				begin
					o_ctrl.usesRt = 1'b1;
					o_ctrl.rtAddr = rtField;
				end
				else
				begin
					o_ctrl.memRead = 1'b1;
					o_ctrl.writesBack = 1'b1;
					o_ctrl.writeAddr = rtField;
				end
			end

			isaPkg::OP_MTC0:
			begin
				o_ctrl.usesAlu = 1'b1;
				o_ctrl.usesRt = 1'b1;
				o_ctrl.rtAddr = rtField;
				case (rdField)
					isaPkg::COP0_PASS: o_ctrl.aluCode = isaPkg::ALU_MTC0_PASS;
					isaPkg::COP0_FAIL: o_ctrl.aluCode = isaPkg::ALU_MTC0_FAIL;
					isaPkg::COP0_DONE: o_ctrl.aluCode = isaPkg::ALU_MTC0_DONE;
					default: o_ctrl.aluCode = isaPkg::ALU_NOP;
				endcase
			end

			default: ;										// unknown opcode, all zero
		endcase
	end

endmodule

`default_nettype wire

//--- src/axiPkg.sv
//********************
// AXI4-Lite channel bundles and the register map of the decode unit.
// Shared by the bus front end and the top level.
//********************
`default_nettype none

package axiPkg;

	typedef logic [5:0] axiAddr;
	typedef logic [31:0] axiData;
	typedef logic [1:0] axiResp;
	typedef logic [3:0] axiStrb;

	localparam axiResp RESP_OKAY = 2'b00;

	typedef struct packed {
		axiAddr awaddr;
		logic awvalid;
		axiData wdata;
		axiStrb wstrb;
		logic wvalid;
		logic bready;
	} axiWriteReq;

	typedef struct packed {
		logic awready;
		logic wready;
		axiResp bresp;
		logic bvalid;
	} axiWriteRsp;

	typedef struct packed {
		axiAddr araddr;
		logic arvalid;
		logic rready;
	} axiReadReq;

	typedef struct packed {
		logic arready;
		axiData rdata;
		axiResp rresp;
		logic rvalid;
	} axiReadRsp;

	// register offsets
	localparam axiAddr REG_PC = 6'h00;
	localparam axiAddr REG_INSTR = 6'h04;
	localparam axiAddr REG_CTRL = 6'h08;		// flags, mask, alu code
	localparam axiAddr REG_REGS = 6'h0c;		// rs, rt, write addresses
	localparam axiAddr REG_IMM = 6'h10;
	localparam axiAddr REG_TARGET = 6'h14;

endpackage

`default_nettype wire

//--- src/isaPkg.sv
//********************
// Instruction set definitions for the decode unit: field encodings,
// ALU control codes, memory size codes and the decoded control struct.
// Referenced by scoped name from the decoder modules.
//********************
`default_nettype none

package isaPkg;

	typedef logic [31:0] instrWord;
	typedef logic [31:0] dataWord;
	typedef logic [4:0] regAddr;
	typedef logic [2:0] memMask;

	localparam memMask MASK_BYTE = 3'd0;
	localparam memMask MASK_BYTE_U = 3'd1;
	localparam memMask MASK_HALF = 3'd2;
	localparam memMask MASK_HALF_U = 3'd3;
	localparam memMask MASK_WORD = 3'd4;

	typedef enum logic [7:0] {
		ALU_NOP = 8'd0,
		ALU_ADD = 8'd1,
		ALU_ADDU = 8'd2,
		ALU_SUB = 8'd3,
		ALU_SUBU = 8'd4,
		ALU_AND = 8'd5,
		ALU_OR = 8'd6,
		ALU_XOR = 8'd7,
		ALU_SLT = 8'd8,
		ALU_SLTU = 8'd9,
		ALU_SLL = 8'd10,
		ALU_SRL = 8'd11,
		ALU_SRA = 8'd12,
		ALU_SLLV = 8'd13,
		ALU_SRLV = 8'd14,
		ALU_SRAV = 8'd15,
		ALU_NOR = 8'd16,
		ALU_LUI = 8'd17,
		ALU_MTC0_PASS = 8'd18,
		ALU_MTC0_FAIL = 8'd19,
		ALU_MTC0_DONE = 8'd20,
		ALU_BA = 8'd32,		// unconditional branch
		ALU_BEQ = 8'd33,
		ALU_BNE = 8'd34,
		ALU_BLEZ = 8'd35,
		ALU_BGTZ = 8'd36,
		ALU_BGEZ = 8'd37,
		ALU_BLTZ = 8'd38,
		ALU_J = 8'd64,
		ALU_JAL = 8'd65,
		ALU_JR = 8'd66,
		ALU_JALR = 8'd67
	} aluCtl;

	// primary opcodes, instr[31:26]
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_REGIMM = 6'h01;	// bgez / bltz
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_BLEZ = 6'h06;
	localparam logic [5:0] OP_BGTZ = 6'h07;
	localparam logic [5:0] OP_ADDI = 6'h08;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI = 6'h0a;
	localparam logic [5:0] OP_SLTIU = 6'h0b;
	localparam logic [5:0] OP_ANDI = 6'h0c;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_XORI = 6'h0e;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_MTC0 = 6'h10;
	localparam logic [5:0] OP_LB = 6'h20;
	localparam logic [5:0] OP_LH = 6'h21;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_LBU = 6'h24;
	localparam logic [5:0] OP_LHU = 6'h25;
	localparam logic [5:0] OP_SB = 6'h28;
	localparam logic [5:0] OP_SH = 6'h29;
	localparam logic [5:0] OP_SW = 6'h2b;

	// R-type function codes, instr[5:0]
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRL = 6'h02;
	localparam logic [5:0] FN_SRA = 6'h03;
	localparam logic [5:0] FN_SLLV = 6'h04;
	localparam logic [5:0] FN_SRLV = 6'h06;
	localparam logic [5:0] FN_SRAV = 6'h07;
	localparam logic [5:0] FN_JR = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_NOR = 6'h27;
	localparam logic [5:0] FN_SLT = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	// mtc0 status codes in the rd field
	localparam regAddr COP0_PASS = 5'h17;
	localparam regAddr COP0_FAIL = 5'h18;
	localparam regAddr COP0_DONE = 5'h19;

	localparam regAddr linkReg = 5'd31;

	typedef enum logic [2:0] {
		KIND_NONE,
		KIND_SHIFT_AMOUNT,
		KIND_SIGN_EXTEND,
		KIND_ZERO_EXTEND,
		KIND_UPPER_IMMEDIATE,
		KIND_LINK,
		KIND_BRANCH_REL,
		KIND_JUMP_ABS
	} operandKind;

	typedef struct packed {
		logic usesAlu;
		logic isBranch;
		logic jumpReg;
		logic memValid;
		logic memRead;		// 1 = load, 0 = store
		logic usesRs;
		logic usesRt;
		logic usesImm;
		logic writesBack;
		memMask memSize;
		aluCtl aluCode;
		regAddr rsAddr;
		regAddr rtAddr;
		regAddr writeAddr;
	} decodedCtrl;

endpackage

`default_nettype wire
